// ==== rtl/cmd_pkg.sv ====
`default_nettype none

package cmd_pkg;

    // ==================================================
    // Message and response widths
    // ==================================================
    localparam int MSG_LEN      = 64;  // Bits after the start bit
    localparam int TYPE_LEN     = 8;
    localparam int ARG_LEN      = 56;
    localparam int RESP_LEN     = 64;
    localparam int HDR_WORD_LEN = 48;
    localparam int HDR_SLOTS    = 4;
    localparam int HDR_IDX_LEN  = $clog2(HDR_SLOTS);
    localparam int LED_LEN      = 4;
    localparam int BIT_CNT_LEN  = $clog2(MSG_LEN + 1);  // Must reach 64

    // Last message bit to first data_out_en cycle, in edges
    localparam int RESP_LATENCY = 3;

    // Argument field positions
    localparam int ARG_IDX_LSB = 48;
    localparam int ARG_LED_LSB = 0;

    // Zero bits between index and header data in a HeaderGet response
    localparam int HDR_PAD_LEN = ARG_LEN - HDR_IDX_LEN - HDR_WORD_LEN;

    // ==================================================
    // Plain vector types
    // ==================================================
    typedef logic [TYPE_LEN-1:0]     msg_type_t;
    typedef logic [ARG_LEN-1:0]      msg_arg_t;
    typedef logic [RESP_LEN-1:0]     resp_t;
    typedef logic [HDR_WORD_LEN-1:0] hdr_word_t;
    typedef logic [HDR_IDX_LEN-1:0]  hdr_idx_t;
    typedef logic [LED_LEN-1:0]      led_t;
    typedef logic [BIT_CNT_LEN-1:0]  bit_cnt_t;

    // Command type codes, anything else is ignored
    localparam msg_type_t TYPE_NOP     = 8'd0;
    localparam msg_type_t TYPE_READY   = 8'd1;
    localparam msg_type_t TYPE_LED_SET = 8'd2;
    localparam msg_type_t TYPE_HDR_SET = 8'd3;
    localparam msg_type_t TYPE_HDR_GET = 8'd4;

    // Type byte goes first on the wire
    typedef struct packed {
        msg_type_t msg_type;
        msg_arg_t  arg;
    } cmd_msg_t;

    // ==================================================
    // FSM states
    // ==================================================
    typedef enum logic {
        RX_IDLE,
        RX_SHIFT
    } rx_state_t;

    typedef enum logic {
        TX_IDLE,
        TX_SHIFT
    } tx_state_t;

endpackage

`default_nettype wire

// ==== rtl/msg_rx.sv ====
`default_nettype none

module msg_rx (
    input  logic              img_clk,
    input  logic              spi_rst_,
    input  logic              data_in,
    output cmd_pkg::cmd_msg_t msg,
    output logic              msg_valid
);

    cmd_pkg::rx_state_t        rx_state;
    cmd_pkg::bit_cnt_t         rx_cnt;
    cmd_pkg::bit_cnt_t         rx_cnt_nxt;
    logic [cmd_pkg::MSG_LEN-1:0] rx_sr;
    logic                      rx_last;

    assign rx_cnt_nxt = rx_cnt + 1'b1;
    // High on the edge that samples the final message bit
    assign rx_last = (rx_state == cmd_pkg::RX_SHIFT) &&
                     (rx_cnt_nxt == cmd_pkg::bit_cnt_t'(cmd_pkg::MSG_LEN));

    // ==================================================
    // Start bit detect and bit counter
    // ==================================================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            rx_state  <= cmd_pkg::RX_IDLE;
            rx_cnt    <= '0;
            msg_valid <= 1'b0;
        end else begin
            msg_valid <= 1'b0;
            case (rx_state)
                cmd_pkg::RX_IDLE: begin
                    if (data_in) begin  // Start bit
                        rx_cnt   <= '0;
                        rx_state <= cmd_pkg::RX_SHIFT;
                    end
                end
                cmd_pkg::RX_SHIFT: begin
                    rx_cnt <= rx_cnt_nxt;
                    if (rx_last) begin
                        msg_valid <= 1'b1;
                        rx_state  <= cmd_pkg::RX_IDLE;  // Ready for next start bit
                    end
                end
                default: rx_state <= cmd_pkg::RX_IDLE;
            endcase
        end
    end

    // Message bits, MSB first
    always_ff @(posedge img_clk) begin
        if (rx_state == cmd_pkg::RX_SHIFT) begin
            rx_sr <= {rx_sr[cmd_pkg::MSG_LEN-2:0], data_in};
        end
    end

    // Held stable while msg_valid is high since the FSM sits in idle
    assign msg = cmd_pkg::cmd_msg_t'(rx_sr);

    // Pulse can never stretch, a message takes at least 65 cycles
    a_msg_valid_pulse: assert property (
        @(posedge img_clk) disable iff (!spi_rst_)
        msg_valid |=> !msg_valid
    );

endmodule

`default_nettype wire

// ==== rtl/cmd_exec.sv ====
`default_nettype none

module cmd_exec (
    input  logic              img_clk,
    input  logic              spi_rst_,
    input  cmd_pkg::cmd_msg_t msg,
    input  logic              msg_valid,
    output cmd_pkg::led_t     led,
    output cmd_pkg::resp_t    resp,
    output logic              resp_valid
);

    cmd_pkg::hdr_word_t hdr_bank [cmd_pkg::HDR_SLOTS];

    cmd_pkg::hdr_idx_t  hdr_idx;
    cmd_pkg::hdr_word_t hdr_wdata;
    cmd_pkg::led_t      led_wdata;
    cmd_pkg::resp_t     resp_nxt;
    logic               resp_hit;   // Command answers on data_out
    logic               led_we;
    logic               hdr_we;

    // Argument fields
    assign hdr_idx   = msg.arg[cmd_pkg::ARG_IDX_LSB +: cmd_pkg::HDR_IDX_LEN];
    assign hdr_wdata = msg.arg[cmd_pkg::HDR_WORD_LEN-1:0];
    assign led_wdata = msg.arg[cmd_pkg::ARG_LED_LSB +: cmd_pkg::LED_LEN];

    // ==================================================
    // Decode
    // ==================================================
    always_comb begin
        resp_nxt = '0;
        resp_hit = 1'b0;
        led_we   = 1'b0;
        hdr_we   = 1'b0;
        case (msg.msg_type)
            cmd_pkg::TYPE_READY: begin
                resp_nxt = {cmd_pkg::TYPE_READY, msg.arg};  // Plain echo
                resp_hit = 1'b1;
            end
            cmd_pkg::TYPE_LED_SET: led_we = 1'b1;
            cmd_pkg::TYPE_HDR_SET: hdr_we = 1'b1;
            cmd_pkg::TYPE_HDR_GET: begin
                resp_nxt = {cmd_pkg::TYPE_HDR_GET,
                            {cmd_pkg::HDR_PAD_LEN{1'b0}},
                            hdr_idx,
                            hdr_bank[hdr_idx]};
                resp_hit = 1'b1;
            end
            // Nop and unknown codes fall through untouched
            default: ;
        endcase
    end

    // ==================================================
    // State updates, one cycle after msg_valid
    // ==================================================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            led        <= '0;
            resp_valid <= 1'b0;
            for (int i = 0; i < cmd_pkg::HDR_SLOTS; i++) begin
                hdr_bank[i] <= '0;
            end
        end else begin
            resp_valid <= msg_valid && resp_hit;
            if (msg_valid && led_we) begin
                led <= led_wdata;
            end
            if (msg_valid && hdr_we) begin
                hdr_bank[hdr_idx] <= hdr_wdata;
            end
        end
    end

    // Response word only matters alongside resp_valid
    always_ff @(posedge img_clk) begin
        if (msg_valid && resp_hit) begin
            resp <= resp_nxt;
        end
    end

    // Every response traces back to a message one cycle earlier
    a_resp_follows_msg: assert property (
        @(posedge img_clk) disable iff (!spi_rst_)
        resp_valid |-> $past(msg_valid)
    );

endmodule

`default_nettype wire

// ==== rtl/resp_tx.sv ====
`default_nettype none

module resp_tx (
    input  logic           img_clk,
    input  logic           spi_rst_,
    input  cmd_pkg::resp_t resp,
    input  logic           resp_valid,
    output logic           data_out,
    output logic           data_out_en
);

    cmd_pkg::tx_state_t tx_state;
    cmd_pkg::bit_cnt_t  tx_cnt;     // Bits already driven
    cmd_pkg::resp_t     tx_sr;
    logic               tx_done;

    assign tx_done = (tx_cnt == cmd_pkg::bit_cnt_t'(cmd_pkg::RESP_LEN));

    // ==================================================
    // Serializer FSM
    // ==================================================
    always_ff @(posedge img_clk or negedge spi_rst_) begin
        if (!spi_rst_) begin
            tx_state    <= cmd_pkg::TX_IDLE;
            tx_cnt      <= '0;
            data_out    <= 1'b0;
            data_out_en <= 1'b0;
        end else begin
            case (tx_state)
                cmd_pkg::TX_IDLE: begin
                    data_out    <= 1'b0;
                    data_out_en <= 1'b0;
                    if (resp_valid) begin
                        tx_cnt   <= '0;
                        tx_state <= cmd_pkg::TX_SHIFT;
                    end
                end
                cmd_pkg::TX_SHIFT: begin
                    if (tx_done) begin
                        data_out    <= 1'b0;
                        data_out_en <= 1'b0;
                        tx_state    <= cmd_pkg::TX_IDLE;
                    end else begin
                        data_out    <= tx_sr[cmd_pkg::RESP_LEN-1];  // MSB first
                        data_out_en <= 1'b1;
                        tx_cnt      <= tx_cnt + 1'b1;
                    end
                end
                default: tx_state <= cmd_pkg::TX_IDLE;
            endcase
        end
    end

    // Load on resp_valid, then shift left once per driven bit
    always_ff @(posedge img_clk) begin
        if (tx_state == cmd_pkg::TX_IDLE && resp_valid) begin
            tx_sr <= resp;
        end else if (tx_state == cmd_pkg::TX_SHIFT) begin
            tx_sr <= {tx_sr[cmd_pkg::RESP_LEN-2:0], 1'b0};
        end
    end

    // No back-pressure, host must wait for the line to go quiet
    a_no_overlap: assert property (
        @(posedge img_clk) disable iff (!spi_rst_)
        (tx_state == cmd_pkg::TX_SHIFT) |-> !resp_valid
    );

endmodule

`default_nettype wire

// ==== rtl/cmd_port_top.sv ====
`default_nettype none

module cmd_port_top (
    input  logic          img_clk,
    input  logic          spi_rst_,
    input  logic          data_in,
    output logic          data_out,
    output logic          data_out_en,
    output cmd_pkg::led_t led
);

    // Decode to execute
    cmd_pkg::cmd_msg_t msg;
    logic              msg_valid;

    // Execute to result
    cmd_pkg::resp_t    resp;
    logic              resp_valid;

    // ==================================================
    // Pipeline: rx, exec, tx
    // ==================================================
    msg_rx u_msg_rx (
        .img_clk   (img_clk),
        .spi_rst_  (spi_rst_),
        .data_in   (data_in),
        .msg       (msg),
        .msg_valid (msg_valid)
    );

    cmd_exec u_cmd_exec (
        .img_clk    (img_clk),
        .spi_rst_   (spi_rst_),
        .msg        (msg),
        .msg_valid  (msg_valid),
        .led        (led),
        .resp       (resp),
        .resp_valid (resp_valid)
    );

    resp_tx u_resp_tx (
        .img_clk     (img_clk),
        .spi_rst_    (spi_rst_),
        .resp        (resp),
        .resp_valid  (resp_valid),
        .data_out    (data_out),
        .data_out_en (data_out_en)
    );

endmodule

`default_nettype wire

// ==== verif/cmd_port_checks.svh ====
`ifndef CMD_PORT_CHECKS_SVH
`define CMD_PORT_CHECKS_SVH

// ==================================================
// Reference model state
// ==================================================
cmd_pkg::led_t      model_led;
cmd_pkg::hdr_word_t model_hdr [cmd_pkg::HDR_SLOTS];

int led_errors    = 0;
int resp_errors   = 0;
int timing_errors = 0;

task automatic model_reset();
    model_led = '0;
    for (int i = 0; i < cmd_pkg::HDR_SLOTS; i++) begin
        model_hdr[i] = '0;
    end
endtask

// Effect of one message on the model
task automatic update_model(input cmd_pkg::msg_type_t t, input cmd_pkg::msg_arg_t arg);
    if (t == cmd_pkg::TYPE_LED_SET) begin
        model_led = arg[3:0];
    end else if (t == cmd_pkg::TYPE_HDR_SET) begin
        model_hdr[arg[49:48]] = arg[47:0];
    end
endtask

// Response word as laid out for Ready and HeaderGet
function automatic cmd_pkg::resp_t expected_resp(input cmd_pkg::msg_type_t t,
                                                 input cmd_pkg::msg_arg_t arg);
    cmd_pkg::resp_t    r;
    cmd_pkg::hdr_idx_t idx;
    r        = '0;
    idx      = arg[49:48];
    r[63:56] = t;
    if (t == cmd_pkg::TYPE_READY) begin
        r[55:0] = arg;  // Plain echo
    end else if (t == cmd_pkg::TYPE_HDR_GET) begin
        r[49:48] = idx;
        r[47:0]  = model_hdr[idx];  // Bits 55 to 50 stay zero
    end
    return r;
endfunction

// ==================================================
// Compare tasks
// ==================================================
task automatic check_led(input cmd_pkg::led_t got, input cmd_pkg::led_t exp);
    if (got !== exp) begin
        led_errors++;
        $display("MISMATCH led: got 0x%h, expected 0x%h at %0t", got, exp, $time);
    end
endtask

task automatic check_resp(input cmd_pkg::resp_t got, input cmd_pkg::resp_t exp);
    if (got !== exp) begin
        resp_errors++;
        $display("MISMATCH data_out: got 0x%h, expected 0x%h at %0t", got, exp, $time);
    end
endtask

task automatic check_timing(input string what, input int got, input int exp);
    if (got != exp) begin
        timing_errors++;
        $display("ERROR: %s was %0d cycles, expected %0d at %0t", what, got, exp, $time);
    end
endtask

// Start bit, then type and argument MSB first
task automatic send_msg(input cmd_pkg::msg_type_t t, input cmd_pkg::msg_arg_t arg);
    cmd_pkg::cmd_msg_t           m;
    logic [cmd_pkg::MSG_LEN-1:0] bits;
    m.msg_type = t;
    m.arg      = arg;
    bits       = m;
    @(posedge img_clk);
    #DRV_DLY;
    data_in = 1'b1;
    for (int i = cmd_pkg::MSG_LEN - 1; i >= 0; i--) begin
        @(posedge img_clk);
        #DRV_DLY;
        data_in = bits[i];
    end
    @(posedge img_clk);  // Samples the last bit
    #DRV_DLY;
    data_in = 1'b0;
    check_led(led, model_led);  // New LED value only from the next edge
endtask

`endif

// ==== verif/cmd_port_tb.sv ====
`default_nettype none

module cmd_port_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int DRV_DLY     = 10;   // Input drive after the rising edge
    localparam int RST_CYCLES  = 10;
    localparam int N_RANDOM    = 200;
    localparam int N_DIRECTED  = 4 * cmd_pkg::HDR_SLOTS + 2;  // Slot readbacks and reset setup
    localparam int MSG_CYCLES  = 1 + cmd_pkg::MSG_LEN + cmd_pkg::RESP_LATENCY +
                                 cmd_pkg::RESP_LEN + 4;
    localparam int MAX_CYCLES  = (N_RANDOM + N_DIRECTED) * MSG_CYCLES +
                                 2 * RST_CYCLES + 20;
    localparam int QUIET_CYCLES  = cmd_pkg::RESP_LATENCY + cmd_pkg::RESP_LEN;
    localparam int LATENCY_LIMIT = cmd_pkg::RESP_LATENCY + 4;

    logic          img_clk;
    logic          spi_rst_;
    logic          data_in;
    logic          data_out;
    logic          data_out_en;
    cmd_pkg::led_t led;

    integer seed;
    int     cycle_cnt = 0;

    `include "cmd_port_checks.svh"

    cmd_port_top u_cmd_port_top (
        .img_clk     (img_clk),
        .spi_rst_    (spi_rst_),
        .data_in     (data_in),
        .data_out    (data_out),
        .data_out_en (data_out_en),
        .led         (led)
    );

    initial begin
        img_clk = 1'b0;
        forever #(CLK_PERIOD / 2) img_clk = ~img_clk;
    end

    // Run limit
    always @(posedge img_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ==================================================
    // Sequencing tasks
    // ==================================================
    task automatic apply_reset();
        spi_rst_ = 1'b0;
        repeat (RST_CYCLES) @(posedge img_clk);
        #DRV_DLY;
        spi_rst_ = 1'b1;
        model_reset();
        check_led(led, '0);
        if (data_out_en !== 1'b0) begin
            timing_errors++;
            $display("ERROR: data_out_en is high right after reset at %0t", $time);
        end
    endtask

    // Response must start after the fixed latency and last RESP_LEN cycles
    task automatic collect_resp(input cmd_pkg::resp_t exp);
        cmd_pkg::resp_t got;
        int             rel;
        int             high_cnt;
        got      = '0;
        rel      = 0;
        high_cnt = 0;
        while (!data_out_en && rel < LATENCY_LIMIT) begin
            @(posedge img_clk);
            #DRV_DLY;
            rel++;
            check_led(led, model_led);
        end
        if (!data_out_en) begin
            timing_errors++;
            $display("ERROR: no response appeared for an answering command at %0t", $time);
            return;
        end
        check_timing("response latency", rel, cmd_pkg::RESP_LATENCY);
        while (data_out_en && high_cnt <= cmd_pkg::RESP_LEN) begin
            got = {got[cmd_pkg::RESP_LEN-2:0], data_out};
            high_cnt++;
            @(posedge img_clk);
            #DRV_DLY;
            check_led(led, model_led);
        end
        check_timing("data_out_en high time", high_cnt, cmd_pkg::RESP_LEN);
        check_resp(got, exp);
    endtask

    task automatic watch_quiet();
        logic seen;
        seen = 1'b0;
        for (int rel = 1; rel <= QUIET_CYCLES; rel++) begin
            @(posedge img_clk);
            #DRV_DLY;
            check_led(led, model_led);
            if (data_out_en && !seen) begin
                seen = 1'b1;
                timing_errors++;
                $display("ERROR: data_out_en rose for a silent command at %0t", $time);
            end
        end
    endtask

    task automatic run_message(input cmd_pkg::msg_type_t t, input cmd_pkg::msg_arg_t arg);
        cmd_pkg::resp_t exp;
        logic           answers;
        answers = (t == cmd_pkg::TYPE_READY) || (t == cmd_pkg::TYPE_HDR_GET);
        exp     = expected_resp(t, arg);
        send_msg(t, arg);
        update_model(t, arg);
        if (answers) begin
            collect_resp(exp);
        end else begin
            watch_quiet();
        end
    endtask

    task automatic random_message(output cmd_pkg::msg_type_t t,
                                  output cmd_pkg::msg_arg_t arg);
        logic [31:0] r_sel;
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        r_sel = $random(seed);
        r_hi  = $random(seed);
        r_lo  = $random(seed);
        arg   = {r_hi[23:0], r_lo};
        case (r_sel[3:0])
            4'd0:                   t = cmd_pkg::TYPE_NOP;
            4'd1, 4'd2:             t = cmd_pkg::TYPE_READY;
            4'd3, 4'd4:             t = cmd_pkg::TYPE_LED_SET;
            4'd5, 4'd6, 4'd7, 4'd8: t = cmd_pkg::TYPE_HDR_SET;
            4'd9, 4'd10, 4'd11, 4'd12: t = cmd_pkg::TYPE_HDR_GET;
            default: begin
                t = r_sel[15:8];
                if (t <= cmd_pkg::TYPE_HDR_GET) begin
                    t = t + 8'd5;  // Keep it outside the known codes
                end
            end
        endcase
    endtask

    // HeaderGet of every slot, random filler in the unused argument bits
    task automatic read_all_slots();
        cmd_pkg::msg_arg_t arg;
        logic [31:0]       r_hi;
        logic [31:0]       r_lo;
        for (int i = 0; i < cmd_pkg::HDR_SLOTS; i++) begin
            r_hi        = $random(seed);
            r_lo        = $random(seed);
            arg         = {r_hi[23:0], r_lo};
            arg[49:48]  = 2'(i);
            run_message(cmd_pkg::TYPE_HDR_GET, arg);
        end
    endtask

    // Nonzero slots and LED, then a Ready response left on the line
    task automatic fill_state_before_reset();
        cmd_pkg::msg_arg_t arg;
        logic [31:0]       r_hi;
        logic [31:0]       r_lo;
        arg = '0;
        for (int i = 0; i < cmd_pkg::HDR_SLOTS; i++) begin
            r_hi       = $random(seed);
            r_lo       = $random(seed);
            arg        = {r_hi[23:0], r_lo};
            arg[49:48] = 2'(i);
            arg[0]     = 1'b1;  // Never an all-zero slot or LED value
            run_message(cmd_pkg::TYPE_HDR_SET, arg);
        end
        run_message(cmd_pkg::TYPE_LED_SET, arg);
        send_msg(cmd_pkg::TYPE_READY, arg);
        repeat (cmd_pkg::RESP_LATENCY) begin
            @(posedge img_clk);
            #DRV_DLY;
        end
        if (data_out_en !== 1'b1) begin
            timing_errors++;
            $display("ERROR: no response on the line before the mid-run reset at %0t", $time);
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int                 total;
        cmd_pkg::msg_type_t t;
        cmd_pkg::msg_arg_t  arg;
        seed     = 32'h90f14f4d;
        data_in  = 1'b0;
        spi_rst_ = 1'b0;
        model_reset();
        apply_reset();
        read_all_slots();
        for (int n = 0; n < N_RANDOM; n++) begin
            if (n == N_RANDOM / 2) begin
                fill_state_before_reset();
                apply_reset();  // Mid-run reset with a response in flight
                read_all_slots();
            end
            random_message(t, arg);
            run_message(t, arg);
        end
        read_all_slots();

        total = led_errors + resp_errors + timing_errors;
        $display("Errors: led %0d, response %0d, timing %0d", led_errors, resp_errors,
                 timing_errors);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verif
rtl/cmd_pkg.sv
rtl/msg_rx.sv
rtl/cmd_exec.sv
rtl/resp_tx.sv
rtl/cmd_port_top.sv
verif/cmd_port_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the command port testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cmd_port_tb \
    -f sim.f

out=$(./obj_dir/Vcmd_port_tb)
echo "$out"

if echo "$out" | grep -q "^SIMULATION PASSED$"; then
    exit 0
fi
echo "run_sim.sh: pass message not found in simulation output"
exit 1
